// ==== common/turbo_pkg.sv ====
// Shared types and constants of the turbo encoder.
// Modules pull these in by a wildcard import in their header.
`default_nettype none

package turbo_pkg;

  // Code rate, sampled with the first beat of a frame.
  typedef enum logic [1:0] {
    code_1by2 = 2'd0,
    code_1by3 = 2'd1,
    code_1by4 = 2'd2,
    code_1by6 = 2'd3
  } code_t;

  // Frame buffer FSM states.
  typedef enum logic [1:0] {
    idle  = 2'd0,
    fill  = 2'd1,
    drain = 2'd2
  } ilv_state_t;

  // Constituent code polynomials, written as the CCSDS tables write them.
  // Bit 4 is the coefficient of D^0 and bit 0 is the coefficient of D^4.
  localparam logic [4:0] poly_fb = 5'b10011;
  localparam logic [4:0] poly_p1 = 5'b11011;
  localparam logic [4:0] poly_p2 = 5'b10101;
  localparam logic [4:0] poly_p3 = 5'b11111;

  // Number of transmitted bits per information bit for each rate.
  // This is also the read pace of the frame buffer in clock cycles.
  function automatic logic [2:0] pace_of(code_t code);
    case (code)
      code_1by2 : return 3'd2;
      code_1by3 : return 3'd3;
      code_1by4 : return 3'd4;
      default   : return 3'd6;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== interleaver/turbo_interleaver.sv ====
// Frame buffer of the turbo encoder. A serial frame is written in, then read
// back as natural and bit-reversed bit pairs, one pair every N cycles.
`default_nettype none

module turbo_interleaver
  import turbo_pkg::*;
#(
  parameter int unsigned frame_bits = 64
) (
  input  logic  iclk,
  input  logic  ireset,
  input  logic  isop,
  input  logic  ival,
  input  logic  ieop,
  input  logic  idat,
  input  code_t icode,
  output logic  obusy,
  output logic  osop,
  output logic  oval,
  output logic  oeop,
  output logic  onat,
  output logic  oilv,
  output code_t ocode
);

  localparam int unsigned addr_w = $clog2(frame_bits);
  localparam logic [addr_w-1:0] last_addr = addr_w'(frame_bits - 1);

  ilv_state_t        state;
  logic [addr_w-1:0] waddr;
  logic [addr_w-1:0] raddr;
  logic [addr_w-1:0] ilv_addr;
  logic [2:0]        pace;
  logic              wr_en;
  logic              rd_en;
  logic [addr_w-1:0] wr_addr;

  logic              mem [frame_bits];

  // A frame is accepted only from its sop beat, and only while the buffer is
  // not draining. Beats during drain are dropped here.
  assign wr_en   = ival & (((state == idle) & isop) | (state == fill));
  assign wr_addr = (state == idle) ? '0 : waddr;

  // One read every N cycles while draining.
  // The pace counter holds off the read right after the last pair.
  assign rd_en = (state == drain) & (pace == 3'd0);

  // The interleaved address is the natural read address with its bits in
  // reverse order.
  always_comb begin
    for (int i = 0; i < addr_w; i++) begin
      ilv_addr[i] = raddr[addr_w-1-i];
    end
  end

  // Input is refused for the whole drain phase.
  assign obusy = (state == drain);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= idle;
      waddr <= '0;
      raddr <= '0;
      pace  <= '0;
      ocode <= code_1by2;
      osop  <= 1'b0;
      oval  <= 1'b0;
      oeop  <= 1'b0;
    end else begin
      // Stream flags are single-cycle pulses.
      oval <= rd_en;
      osop <= rd_en & (raddr == '0);
      oeop <= rd_en & (raddr == last_addr);
      case (state)
        idle : begin
          if (ival & isop) begin
            // The rate holds for the whole frame.
            ocode <= icode;
            waddr <= addr_w'(1);
            state <= fill;
          end
        end
        fill : begin
          if (ival) begin
            waddr <= waddr + 1'b1;
            if (ieop) begin
              // The first read goes out on the next cycle.
              raddr <= '0;
              pace  <= '0;
              state <= drain;
            end
          end
        end
        drain : begin
          if (rd_en) begin
            raddr <= raddr + 1'b1;
            pace  <= pace_of(ocode) - 3'd1;
          end else if (pace != 3'd0) begin
            pace <= pace - 3'd1;
          end
          // Release the input one cycle after the last pair leaves.
          if (oeop) begin
            state <= idle;
          end
        end
        default : begin
          state <= idle;
        end
      endcase
    end
  end

  // The bit array itself.
  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[wr_addr] <= idat;
    end
  end

  // Both bits of a pair are read in the same cycle.
  always_ff @(posedge iclk) begin
    if (rd_en) begin
      onat <= mem[raddr];
      oilv <= mem[ilv_addr];
    end
  end

endmodule

`default_nettype wire

// ==== logic/turbo_conv_enc.sv ====
// 16-state recursive systematic constituent encoder.
// Emits the systematic bit and three parities, one cycle after each input bit.
`default_nettype none

module turbo_conv_enc
  import turbo_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       isop,
  input  logic       ival,
  input  logic       ieop,
  input  logic       idat,
  output logic       osop,
  output logic       oval,
  output logic       oeop,
  output logic [3:0] osym
);

  // Shift state. sreg[k-1] holds the feedback bit delayed by k cycles.
  logic [3:0] sreg;
  logic [3:0] cur;
  logic       fb;
  logic [3:0] par;

  // XOR of the taps of one polynomial over the register bit a and the state.
  function automatic logic tap_xor(logic [4:0] poly, logic a, logic [3:0] s);
    logic acc;
    acc = poly[4] & a;
    for (int k = 1; k <= 4; k++) begin
      acc = acc ^ (poly[4-k] & s[k-1]);
    end
    return acc;
  endfunction

  always_comb begin
    // A new frame starts from the all-zero state.
    cur = isop ? 4'd0 : sreg;
    // The D^0 tap of the feedback polynomial is the input itself.
    fb  = idat ^ tap_xor(poly_fb, 1'b0, cur);
    par[0] = idat;
    par[1] = tap_xor(poly_p1, fb, cur);
    par[2] = tap_xor(poly_p2, fb, cur);
    par[3] = tap_xor(poly_p3, fb, cur);
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sreg <= '0;
      osop <= 1'b0;
      oval <= 1'b0;
      oeop <= 1'b0;
    end else begin
      osop <= ival & isop;
      oval <= ival;
      oeop <= ival & ieop;
      if (ival) begin
        sreg <= {cur[2:0], fb};
      end
    end
  end

  // The symbol word holds the systematic bit in bit 0 and the parities in
  // bits 1 to 3.
  always_ff @(posedge iclk) begin
    if (ival) begin
      osym <= par;
    end
  end

endmodule

`default_nettype wire

// ==== logic/turbo_punct.sv ====
// Puncturer and serializer for rates 1/2, 1/3, 1/4 and 1/6.
// Each symbol pair is loaded once and shifted out over N cycles.
`default_nettype none

module turbo_punct
  import turbo_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  code_t      icode,
  input  logic       isop,
  input  logic       ival,
  input  logic       ieop,
  input  logic [3:0] idat [2],
  output logic       osop,
  output logic       oval,
  output logic       oeop,
  output logic       odat
);

  logic       sop;
  logic [5:0] val;
  logic [5:0] eop;
  logic       sel;
  logic [5:0] dat;

  // The valid mask holds N ones and the eop mask marks bit N-1.
  // Both shift right between input beats.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sop <= 1'b0;
      val <= '0;
      eop <= '0;
      sel <= 1'b0;
    end else begin
      sop <= isop & ival;
      if (ival) begin
        // At rate 1/2 the parity source toggles every beat.
        // Encoder a is taken on sop, so encoder b comes next.
        sel <= isop ? 1'b1 : ~sel;
        case (icode)
          code_1by2 : begin
            val <= 6'b000011;
            eop <= 6'b000010 & {6{ieop}};
          end
          code_1by3 : begin
            val <= 6'b000111;
            eop <= 6'b000100 & {6{ieop}};
          end
          code_1by4 : begin
            val <= 6'b001111;
            eop <= 6'b001000 & {6{ieop}};
          end
          code_1by6 : begin
            val <= 6'b111111;
            eop <= 6'b100000 & {6{ieop}};
          end
          default : begin
            val <= '0;
            eop <= '0;
          end
        endcase
      end else begin
        val <= val >> 1;
        eop <= eop >> 1;
      end
    end
  end

  // Bit 0 of the data register is the bit on the wire.
  // Unused upper bits are loaded with zero.
  always_ff @(posedge iclk) begin
    if (ival) begin
      case (icode)
        code_1by2 : begin
          dat <= {4'b0, (isop ? idat[0][1] : idat[sel][1]), idat[0][0]};
        end
        code_1by3 : begin
          dat <= {3'b0, idat[1][1], idat[0][1], idat[0][0]};
        end
        code_1by4 : begin
          dat <= {2'b0, idat[1][1], idat[0][3], idat[0][2], idat[0][0]};
        end
        default : begin
          // Rate 1/6 sends every parity of a and parities 1 and 3 of b.
          dat <= {idat[1][3], idat[1][1], idat[0][3], idat[0][2], idat[0][1],
                  idat[0][0]};
        end
      endcase
    end else begin
      dat <= dat >> 1;
    end
  end

  assign osop = sop;
  assign oval = val[0];
  assign oeop = eop[0];
  assign odat = dat[0];

endmodule

`default_nettype wire

// ==== logic/turbo_enc_top.sv ====
// Top level of the turbo encoder. A serial frame goes in, and the punctured
// coded stream comes out at N times the frame length.
`default_nettype none

module turbo_enc_top
  import turbo_pkg::*;
#(
  parameter int unsigned frame_bits = 64
) (
  input  logic  iclk,
  input  logic  ireset,
  input  code_t icode,
  input  logic  isop,
  input  logic  ival,
  input  logic  ieop,
  input  logic  idat,
  output logic  obusy,
  output logic  osop,
  output logic  oval,
  output logic  oeop,
  output logic  odat
);

  // Read stream of the frame buffer.
  logic       enc_sop;
  logic       enc_val;
  logic       enc_eop;
  logic       bit_nat;
  logic       bit_ilv;
  code_t      enc_code;

  // Symbols from both encoders. Index 0 is encoder a.
  logic [3:0] sym [2];
  logic       sym_sop;
  logic       sym_val;
  logic       sym_eop;
  code_t      sym_code;

  turbo_interleaver #(
    .frame_bits (frame_bits)
  ) u_ilv (
    .iclk   (iclk),
    .ireset (ireset),
    .isop   (isop),
    .ival   (ival),
    .ieop   (ieop),
    .idat   (idat),
    .icode  (icode),
    .obusy  (obusy),
    .osop   (enc_sop),
    .oval   (enc_val),
    .oeop   (enc_eop),
    .onat   (bit_nat),
    .oilv   (bit_ilv),
    .ocode  (enc_code)
  );

  turbo_conv_enc enc_a (
    .iclk   (iclk),
    .ireset (ireset),
    .isop   (enc_sop),
    .ival   (enc_val),
    .ieop   (enc_eop),
    .idat   (bit_nat),
    .osop   (sym_sop),
    .oval   (sym_val),
    .oeop   (sym_eop),
    .osym   (sym[0])
  );

  // Encoder b runs in lockstep with a, so its own flags are left open.
  turbo_conv_enc enc_b (
    .iclk   (iclk),
    .ireset (ireset),
    .isop   (enc_sop),
    .ival   (enc_val),
    .ieop   (enc_eop),
    .idat   (bit_ilv),
    .osop   (),
    .oval   (),
    .oeop   (),
    .osym   (sym[1])
  );

  // The rate follows the symbols through the encoder stage.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sym_code <= code_1by2;
    end else begin
      sym_code <= enc_code;
    end
  end

  turbo_punct u_punct (
    .iclk   (iclk),
    .ireset (ireset),
    .icode  (sym_code),
    .isop   (sym_sop),
    .ival   (sym_val),
    .ieop   (sym_eop),
    .idat   (sym),
    .osop   (osop),
    .oval   (oval),
    .oeop   (oeop),
    .odat   (odat)
  );

endmodule

`default_nettype wire

// ==== dv/turbo_enc_chk.sv ====
// Protocol assertions on the turbo encoder top level, bound in by the testbench.
`default_nettype none

module turbo_enc_chk
  import turbo_pkg::*;
(
  input logic       iclk,
  input logic       ireset,
  input logic       isop,
  input logic       ival,
  input logic       ieop,
  input logic       obusy,
  input logic       osop,
  input logic       oval,
  input logic       oeop,
  input ilv_state_t ilv_state
);

  int unsigned fail_cnt = 0;
  logic        seen_sop;

  // Goes high with the first sop beat after reset and stays high.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      seen_sop <= 1'b0;
    end else if (ival & isop) begin
      seen_sop <= 1'b1;
    end
  end

  // Nothing moves on the outputs before the first frame arrives.
  a_quiet : assert property (@(posedge iclk) disable iff (ireset)
    !seen_sop |-> !(obusy | oval | osop | oeop))
    else begin $error("Output active before the first frame"); fail_cnt++; end

  // The serial output has no gaps inside a frame.
  a_gapless : assert property (@(posedge iclk) disable iff (ireset)
    (oval & !oeop) |=> oval)
    else begin $error("Gap in oval inside a frame"); fail_cnt++; end

  a_busy_rise : assert property (@(posedge iclk) disable iff (ireset)
    (ival & ieop & (ilv_state == fill)) |=> obusy)
    else begin $error("obusy did not rise after the input eop"); fail_cnt++; end

  a_flags : assert property (@(posedge iclk) disable iff (ireset)
    (osop | oeop) |-> oval)
    else begin $error("Frame flag without oval"); fail_cnt++; end

endmodule

`default_nettype wire

// ==== dv/turbo_enc_tb.sv ====
// Testbench for the turbo encoder top level. Four LFSR frames, one per code
// rate, are sent in and the serial output is checked against a bit-level model.
`default_nettype none

module turbo_enc_tb
  import turbo_pkg::*;
();

  localparam int frame_len = 64;

  logic  iclk = 1'b0;
  logic  ireset;
  code_t icode;
  logic  isop;
  logic  ival;
  logic  ieop;
  logic  idat;
  logic  obusy;
  logic  osop;
  logic  oval;
  logic  oeop;
  logic  odat;

  // Data bits of the frame in flight, and the expected serial output.
  logic [15:0] lfsr_state;
  logic        frame [frame_len];
  logic        expq [$];
  logic        want;
  logic        last_bit;
  int          out_cnt;

  turbo_enc_top #(
    .frame_bits (frame_len)
  ) dut (
    .iclk   (iclk),
    .ireset (ireset),
    .icode  (icode),
    .isop   (isop),
    .ival   (ival),
    .ieop   (ieop),
    .idat   (idat),
    .obusy  (obusy),
    .osop   (osop),
    .oval   (oval),
    .oeop   (oeop),
    .odat   (odat)
  );

  bind turbo_enc_top turbo_enc_chk u_chk (
    .iclk      (iclk),
    .ireset    (ireset),
    .isop      (isop),
    .ival      (ival),
    .ieop      (ieop),
    .obusy     (obusy),
    .osop      (osop),
    .oval      (oval),
    .oeop      (oeop),
    .ilv_state (u_ilv.state)
  );

  always #2 iclk = ~iclk;

  // Fibonacci LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // The interleaver reads the frame at the mirrored address.
  function automatic logic [5:0] reverse_addr(logic [5:0] a);
    logic [5:0] r;
    for (int i = 0; i < 6; i++) begin
      r[i] = a[5-i];
    end
    return r;
  endfunction

  // One step of a recursive systematic code. hist[3] holds the feedback bit
  // of the previous step and hist[0] the one from four steps back.
  task automatic rsc_step(inout logic [3:0] hist, input logic d, output logic [2:0] par);
    logic       w;
    logic [4:0] win;
    w = d ^ (^(poly_fb[3:0] & hist));
    win = {w, hist};
    par[0] = ^(poly_p1 & win);
    par[1] = ^(poly_p2 & win);
    par[2] = ^(poly_p3 & win);
    hist = {w, hist[3:1]};
  endtask

  // Encodes the current frame with both encoders and queues the punctured bits.
  task automatic build_expected(code_t code);
    logic [3:0] hist_a;
    logic [3:0] hist_b;
    logic [2:0] par_a;
    logic [2:0] par_b;
    hist_a = '0;
    hist_b = '0;
    for (int k = 0; k < frame_len; k++) begin
      rsc_step(hist_a, frame[k], par_a);
      rsc_step(hist_b, frame[reverse_addr(6'(k))], par_b);
      expq.push_back(frame[k]);
      case (code)
        code_1by2 : begin
          // Parity 1 alternates between the encoders and starts with a.
          expq.push_back((k % 2 == 0) ? par_a[0] : par_b[0]);
        end
        code_1by3 : begin
          expq.push_back(par_a[0]);
          expq.push_back(par_b[0]);
        end
        code_1by4 : begin
          expq.push_back(par_a[1]);
          expq.push_back(par_a[2]);
          expq.push_back(par_b[0]);
        end
        default : begin
          expq.push_back(par_a[0]);
          expq.push_back(par_a[1]);
          expq.push_back(par_a[2]);
          expq.push_back(par_b[0]);
          expq.push_back(par_b[2]);
        end
      endcase
    end
  endtask

  task automatic fail_value(string name, logic got, logic exp_val);
    $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, name, got, exp_val);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first mismatch");
  endtask

  task automatic fail_msg(string what);
    $display("Error at time %0t: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic wait_busy_low(int limit);
    int n;
    n = 0;
    while (obusy) begin
      @(negedge iclk);
      n++;
      if (n > limit) begin
        fail_msg("obusy did not fall before the timeout");
      end
    end
  endtask

  task automatic wait_frame_end(int limit);
    int n;
    n = 0;
    do begin
      @(negedge iclk);
      n++;
      if (n > limit) begin
        fail_msg("no oeop seen before the timeout");
      end
    end while (!(oval && oeop));
  endtask

  // Drives one frame and then an extra beat while the buffer is busy.
  task automatic send_frame(code_t code);
    for (int i = 0; i < frame_len; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      frame[i] = lfsr_state[0];
    end
    build_expected(code);
    for (int i = 0; i < frame_len; i++) begin
      @(posedge iclk);
      #1;
      // Only the sop beat carries the real rate.
      icode = (i == 0) ? code : code_t'(~code);
      ival = 1'b1;
      isop = (i == 0);
      ieop = (i == frame_len - 1);
      idat = frame[i];
    end
    @(negedge iclk);
    assert (obusy === 1'b0) else fail_value("obusy", obusy, 1'b0);
    @(posedge iclk);
    #1;
    ival = 1'b1;
    isop = 1'b1;
    ieop = 1'b1;
    idat = ~frame[0];
    @(negedge iclk);
    assert (obusy === 1'b1) else fail_value("obusy", obusy, 1'b1);
    @(posedge iclk);
    #1;
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
    idat = 1'b0;
    wait_busy_low(frame_len * 6 + 16);
    wait_frame_end(32);
    @(negedge iclk);
    assert (expq.size() == 0) else fail_msg("output frame ended before all expected bits");
    repeat (4) @(posedge iclk);
  endtask

  // Output monitor. Every oval bit is taken from the head of the model queue.
  always @(negedge iclk) begin
    if (!ireset) begin
      if (oval) begin
        assert (expq.size() > 0) else fail_msg("oval seen with no expected bit left");
        last_bit = (expq.size() == 1);
        want = expq.pop_front();
        assert (odat === want) else fail_value("odat", odat, want);
        assert (osop === (out_cnt == 0)) else fail_value("osop", osop, out_cnt == 0);
        assert (oeop === last_bit) else fail_value("oeop", oeop, last_bit);
        out_cnt = last_bit ? 0 : out_cnt + 1;
      end else begin
        assert (!osop && !oeop) else fail_msg("osop or oeop seen without oval");
      end
    end
  end

  // A failed protocol assertion in the bound checker ends the run at once.
  always @(negedge iclk) begin
    if (dut.u_chk.fail_cnt != 0) begin
      fail_msg("a protocol assertion in the bound checker failed");
    end
  end

  initial begin
    ireset = 1'b1;
    icode = code_1by2;
    isop = 1'b0;
    ival = 1'b0;
    ieop = 1'b0;
    idat = 1'b0;
    out_cnt = 0;
    lfsr_state = 16'd12484;
    repeat (2) @(posedge iclk);
    #1;
    ireset = 1'b0;
    repeat (3) @(posedge iclk);
    send_frame(code_1by2);
    send_frame(code_1by3);
    send_frame(code_1by4);
    send_frame(code_1by6);
    if (dut.u_chk.fail_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "Protocol assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/turbo_pkg.sv
interleaver/turbo_interleaver.sv
logic/turbo_conv_enc.sv
logic/turbo_punct.sv
logic/turbo_enc_top.sv
dv/turbo_enc_chk.sv
dv/turbo_enc_tb.sv

// ==== Makefile ====
# Verilator flow for the turbo encoder.

TOP := turbo_enc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module turbo_enc_top -f compile.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
